// File: source/vfuPkg.sv
package vfuPkg;

    localparam int wordW = 32;

    typedef logic [wordW-1:0] wordT;

    typedef enum logic [2:0] {
        vfuPassVs1 = 3'd0,
        vfuPassVs2 = 3'd1,
        vfuAlu     = 3'd2,
        vfuMul     = 3'd3,
        vfuDiv     = 3'd4
    } vfuSelT;

    typedef enum logic [4:0] {
        valuAdd     = 5'd0,
        valuSub     = 5'd1,
        valuRsb     = 5'd2,
        valuExt     = 5'd3,
        valuAdc     = 5'd4,
        valuSbc     = 5'd5,
        valuMadcNoC = 5'd6,
        valuMadc    = 5'd7,
        valuMsbcNoB = 5'd8,
        valuMsbc    = 5'd9,
        valuAnd     = 5'd10,
        valuNand    = 5'd11,
        valuAndn    = 5'd12,
        valuOr      = 5'd13,
        valuNor     = 5'd14,
        valuOrn     = 5'd15,
        valuXor     = 5'd16,
        valuXnor    = 5'd17,
        valuSrl     = 5'd18,
        valuSra     = 5'd19,
        valuSll     = 5'd20,
        valuSeq     = 5'd21,
        valuSne     = 5'd22,
        valuSlt     = 5'd23,
        valuSle     = 5'd24,
        valuSgt     = 5'd25,
        valuMin     = 5'd26,
        valuMax     = 5'd27,
        valuMerge   = 5'd28,
        valuIntMove = 5'd29
    } valuOpT;

    // mul and div reuse the alu opcode field
    localparam valuOpT mulLow  = valuAdd;
    localparam valuOpT mulHigh = valuSlt;
    localparam valuOpT divQuot = valuAdd;
    localparam valuOpT divRem  = valuSub;

    typedef enum logic [1:0] {
        sew8  = 2'd0,
        sew16 = 2'd1,
        sew32 = 2'd2
    } vsewT;

endpackage

// File: source/vecAlu.sv
module vecAlu import vfuPkg::*; (
    input  valuOpT aluOp,
    input  vsewT   vsew,
    input  logic   opUnsigned,
    input  logic   maskBit,
    input  wordT   vopA,
    input  wordT   vopB,
    output wordT   aluRes
);

    logic [wordW:0] carrySum;
    logic [wordW:0] borrowDiff;
    logic           carryIn;
    logic [4:0]     shamt;
    logic           aEqB;
    logic           aLtB;

    // no-carry forms ignore the mask bit
    assign carryIn = (aluOp == valuMadcNoC || aluOp == valuMsbcNoB) ? 1'b0 : maskBit;

    assign carrySum   = {1'b0, vopA} + {1'b0, vopB} + {{wordW{1'b0}}, carryIn};
    assign borrowDiff = {1'b0, vopA} - {1'b0, vopB} - {{wordW{1'b0}}, carryIn};

    assign aEqB = (vopA == vopB);
    assign aLtB = opUnsigned ? (vopA < vopB) : ($signed(vopA) < $signed(vopB));

    always_comb begin
        case (vsew)
            sew8:    shamt = {2'b00, vopB[2:0]};
            sew16:   shamt = {1'b0, vopB[3:0]};
            default: shamt = vopB[4:0];
        endcase
    end

    always_comb begin
        case (aluOp)
            valuAdd:     aluRes = vopA + vopB;
            valuSub:     aluRes = vopA - vopB;
            valuRsb:     aluRes = vopB - vopA;
            valuExt:     aluRes = vopA;
            valuAdc:     aluRes = carrySum[wordW-1:0];
            valuSbc:     aluRes = borrowDiff[wordW-1:0];
            valuMadcNoC,
            valuMadc:    aluRes = {{(wordW-1){1'b0}}, carrySum[wordW]}; // carry out
            valuMsbcNoB,
            valuMsbc:    aluRes = {{(wordW-1){1'b0}}, borrowDiff[wordW]}; // borrow out
            valuAnd:     aluRes = vopA & vopB;
            valuNand:    aluRes = ~(vopA & vopB);
            valuAndn:    aluRes = vopA & ~vopB;
            valuOr:      aluRes = vopA | vopB;
            valuNor:     aluRes = ~(vopA | vopB);
            valuOrn:     aluRes = vopA | ~vopB;
            valuXor:     aluRes = vopA ^ vopB;
            valuXnor:    aluRes = ~(vopA ^ vopB);
            valuSrl:     aluRes = vopA >> shamt;
            valuSra:     aluRes = $signed(vopA) >>> shamt;
            valuSll:     aluRes = vopA << shamt;
            valuSeq:     aluRes = {{(wordW-1){1'b0}}, aEqB};
            valuSne:     aluRes = {{(wordW-1){1'b0}}, ~aEqB};
            valuSlt:     aluRes = {{(wordW-1){1'b0}}, aLtB};
            valuSle:     aluRes = {{(wordW-1){1'b0}}, aLtB | aEqB};
            valuSgt:     aluRes = {{(wordW-1){1'b0}}, ~(aLtB | aEqB)};
            valuMin:     aluRes = aLtB ? vopA : vopB;
            valuMax:     aluRes = aLtB ? vopB : vopA;
            valuMerge:   aluRes = maskBit ? vopB : vopA;
            valuIntMove: aluRes = vopB;
            default:     aluRes = '0;
        endcase
    end

endmodule

// File: source/vecMultiplier.sv
module vecMultiplier import vfuPkg::*; #(
    parameter int mulBitsPerCycle = 1
) (
    input  logic CLK,
    input  logic rstN,
    input  logic mulEn,
    input  logic retHigh,
    input  logic opUnsigned,
    input  wordT vopA,
    input  wordT vopB,
    output logic busy,
    output wordT mulRes
);

    localparam int steps = wordW / mulBitsPerCycle;
    localparam int cntW  = $clog2(steps);

    logic                 running;
    logic [cntW-1:0]      cnt;
    logic                 negRes;
    logic                 highSel;
    logic [2*wordW-1:0]   mcand;
    logic [2*wordW-1:0]   acc;
    logic [2*wordW-1:0]   srcCand;
    logic [2*wordW-1:0]   srcAcc;
    logic [2*wordW-1:0]   accNext;
    logic [2*wordW-1:0]   product;
    wordT                 mplier;
    wordT                 srcPlier;
    wordT                 magA;
    wordT                 magB;

    assign magA = (!opUnsigned && vopA[wordW-1]) ? -vopA : vopA;
    assign magB = (!opUnsigned && vopB[wordW-1]) ? -vopB : vopB;

    assign busy = mulEn | running; // start cycle counts as busy

    // first digit is taken straight from the inputs on the start cycle
    always_comb begin
        srcCand  = running ? mcand : {{wordW{1'b0}}, magA};
        srcPlier = running ? mplier : magB;
        srcAcc   = running ? acc : '0;
        accNext  = srcAcc;
        for (int i = 0; i < mulBitsPerCycle; i++) begin
            if (srcPlier[i]) begin
                accNext = accNext + (srcCand << i);
            end
        end
    end

    assign product = negRes ? -accNext : accNext;

    always_ff @(posedge CLK) begin
        if (mulEn || running) begin
            acc    <= accNext;
            mcand  <= srcCand << mulBitsPerCycle;
            mplier <= srcPlier >> mulBitsPerCycle;
        end
        if (mulEn) begin
            negRes  <= !opUnsigned && (vopA[wordW-1] ^ vopB[wordW-1]);
            highSel <= retHigh;
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            running <= 1'b0;
            cnt     <= '0;
            mulRes  <= '0;
        end else if (mulEn) begin
            running <= 1'b1;
            cnt     <= cntW'(steps - 1);
        end else if (running) begin
            cnt <= cnt - 1'b1;
            if (cnt == cntW'(1)) begin // last digit
                running <= 1'b0;
                mulRes  <= highSel ? product[2*wordW-1:wordW] : product[wordW-1:0];
            end
        end
    end

    assert property (@(posedge CLK) disable iff (!rstN) mulEn |-> !running)
        else $error("multiplier restarted while in flight");

endmodule

// File: source/vecDivider.sv
module vecDivider import vfuPkg::*; (
    input  logic CLK,
    input  logic rstN,
    input  logic divEn,
    input  logic retRem,
    input  logic opUnsigned,
    input  wordT vopA,
    input  wordT vopB,
    output logic busy,
    output wordT divRes
);

    logic           running;
    logic [4:0]     cnt;
    logic           divZero;
    logic           negQuo;
    logic           negRem;
    logic           remSel;
    logic           fits;
    logic [wordW:0] remShift;
    wordT           magA;
    wordT           magB;
    wordT           dvdHeld;
    wordT           dvsr;
    wordT           quo;
    wordT           rem;
    wordT           srcQuo;
    wordT           srcRem;
    wordT           srcDvsr;
    wordT           quoNext;
    wordT           remNext;
    wordT           quoFix;
    wordT           remFix;

    assign magA = (!opUnsigned && vopA[wordW-1]) ? -vopA : vopA;
    assign magB = (!opUnsigned && vopB[wordW-1]) ? -vopB : vopB;

    assign busy = divEn | running;

    // one restoring step, first one runs on the start cycle
    always_comb begin
        srcQuo   = running ? quo : magA;
        srcRem   = running ? rem : '0;
        srcDvsr  = running ? dvsr : magB;
        remShift = {srcRem, srcQuo[wordW-1]};
        fits     = (remShift >= {1'b0, srcDvsr});
        remNext  = fits ? wordT'(remShift - {1'b0, srcDvsr}) : remShift[wordW-1:0];
        quoNext  = {srcQuo[wordW-2:0], fits};
    end

    // most negative / -1 already comes out right from the magnitudes
    assign quoFix = negQuo ? -quo : quo;
    assign remFix = negRem ? -rem : rem;

    always_ff @(posedge CLK) begin
        if (divEn || (running && cnt != '0)) begin
            quo <= quoNext;
            rem <= remNext;
        end
        if (divEn) begin
            dvsr    <= magB;
            dvdHeld <= vopA;
            divZero <= (vopB == '0);
            negQuo  <= !opUnsigned && (vopA[wordW-1] ^ vopB[wordW-1]);
            negRem  <= !opUnsigned && vopA[wordW-1]; // remainder follows dividend
            remSel  <= retRem;
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            running <= 1'b0;
            cnt     <= '0;
            divRes  <= '0;
        end else if (divEn) begin
            running <= 1'b1;
            cnt     <= 5'd31;
        end else if (running) begin
            if (cnt == '0) begin // sign fix-up cycle
                running <= 1'b0;
                if (remSel) begin
                    divRes <= divZero ? dvdHeld : remFix;
                end else begin
                    divRes <= divZero ? '1 : quoFix;
                end
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assert property (@(posedge CLK) disable iff (!rstN) divEn |-> !running)
        else $error("divider restarted while in flight");

endmodule

// File: source/vecFuncUnit.sv
module vecFuncUnit import vfuPkg::*; #(
    parameter int mulBitsPerCycle = 1
) (
    input  logic   CLK,
    input  logic   rstN,
    input  logic   start,
    input  vfuSelT funcSel,
    input  valuOpT aluOp,
    input  vsewT   vsew,
    input  logic   opUnsigned,
    input  logic   maskBit,
    input  wordT   vopA,
    input  wordT   vopB,
    input  wordT   vopC,
    output wordT   vres,
    output logic   stall
);

    wordT aluRes;
    wordT mulRes;
    wordT divRes;
    logic mulSel;
    logic divSel;
    logic mulEn;
    logic divEn;
    logic mulBusy;
    logic divBusy;

    assign mulSel = (funcSel == vfuMul);
    assign divSel = (funcSel == vfuDiv);
    assign mulEn  = start & mulSel & ~maskBit; // masked elements never start
    assign divEn  = start & divSel & ~maskBit;
    assign stall  = (mulSel & mulBusy) | (divSel & divBusy);

    vecAlu uAlu (
        .aluOp(aluOp), .vsew(vsew), .opUnsigned(opUnsigned), .maskBit(maskBit),
        .vopA(vopA), .vopB(vopB), .aluRes(aluRes)
    );

    vecMultiplier #(.mulBitsPerCycle(mulBitsPerCycle)) uMul (
        .CLK(CLK), .rstN(rstN), .mulEn(mulEn), .retHigh(aluOp == mulHigh),
        .opUnsigned(opUnsigned), .vopA(vopA), .vopB(vopB), .busy(mulBusy), .mulRes(mulRes)
    );

    vecDivider uDiv (
        .CLK(CLK), .rstN(rstN), .divEn(divEn), .retRem(aluOp == divRem),
        .opUnsigned(opUnsigned), .vopA(vopA), .vopB(vopB), .busy(divBusy), .divRes(divRes)
    );

    always_comb begin
        case (funcSel)
            vfuPassVs1: vres = vopB; // operands cross, as in the scalar path
            vfuPassVs2: vres = vopA;
            vfuAlu:     vres = aluRes;
            vfuMul:     vres = mulRes;
            vfuDiv:     vres = divRes;
            default:    vres = '0;
        endcase
    end

endmodule

// File: source/vecLane.sv
module vecLane import vfuPkg::*; #(
    parameter int mulBitsPerCycle = 2
) (
    input  logic   CLK,
    input  logic   rstN,
    input  logic   opValid,
    input  vfuSelT funcSel,
    input  valuOpT aluOp,
    input  vsewT   vsew,
    input  logic   opUnsigned,
    input  logic   maskBit,
    input  wordT   vopA,
    input  wordT   vopB,
    input  wordT   vopC,
    output logic   opReady,
    output logic   resValid,
    output wordT   vres
);

    typedef enum logic [1:0] {
        stIdle,
        stIssue,
        stWait
    } laneStateT;

    laneStateT state;
    vfuSelT    selR;
    valuOpT    opR;
    vsewT      sewR;
    logic      unsR;
    logic      maskR;
    wordT      aR;
    wordT      bR;
    wordT      cR;
    wordT      fuRes;
    logic      fuStall;

    assign opReady = (state == stIdle);

    always_ff @(posedge CLK) begin
        if (opValid && opReady) begin // hold request for the whole op
            selR  <= funcSel;
            opR   <= aluOp;
            sewR  <= vsew;
            unsR  <= opUnsigned;
            maskR <= maskBit;
            aR    <= vopA;
            bR    <= vopB;
            cR    <= vopC;
        end
        if (state == stWait && !fuStall) begin
            vres <= fuRes;
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            state    <= stIdle;
            resValid <= 1'b0;
        end else begin
            resValid <= 1'b0;
            case (state)
                stIdle: begin
                    if (opValid) begin
                        state <= stIssue;
                    end
                end
                stIssue: state <= stWait; // start pulse goes out here
                stWait: begin
                    if (!fuStall) begin
                        state    <= stIdle;
                        resValid <= 1'b1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    vecFuncUnit #(.mulBitsPerCycle(mulBitsPerCycle)) uFu (
        .CLK(CLK), .rstN(rstN), .start(state == stIssue), .funcSel(selR), .aluOp(opR),
        .vsew(sewR), .opUnsigned(unsR), .maskBit(maskR), .vopA(aR), .vopB(bR), .vopC(cR),
        .vres(fuRes), .stall(fuStall)
    );

    assert property (@(posedge CLK) disable iff (!rstN) resValid |=> !resValid)
        else $error("result valid held for more than one cycle");

endmodule

// File: tests/vecLaneTb.sv
module vecLaneTb import vfuPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic   CLK;
    logic   rstN;
    logic   opValid;
    vfuSelT funcSel;
    valuOpT aluOp;
    vsewT   vsew;
    logic   opUnsigned;
    logic   maskBit;
    wordT   vopA;
    wordT   vopB;
    wordT   vopC;
    logic   opReady;
    logic   resValid;
    wordT   vres;

    int   mismatches;
    int   otherErrors;
    int   timeouts;
    int   checks;
    int   accepted;
    int   pulses = 0;
    logic timedOut;

    vecLane dut (
        .CLK(CLK), .rstN(rstN), .opValid(opValid), .funcSel(funcSel), .aluOp(aluOp),
        .vsew(vsew), .opUnsigned(opUnsigned), .maskBit(maskBit), .vopA(vopA), .vopB(vopB),
        .vopC(vopC), .opReady(opReady), .resValid(resValid), .vres(vres)
    );

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        if (resValid) begin
            pulses <= pulses + 1; // every pulse, expected or not
        end
    end

    // outputs are read right at the rising edge, before the flops update
    task automatic applyVector(input int sel, input int op, input int sew, input int uns,
                               input int mask, input wordT a, input wordT b,
                               input wordT expVal, input string testName);
        int   waitCnt;
        int   cycles;
        logic gotRes;
        wordT got;
        waitCnt = 0;
        cycles  = 0;
        gotRes  = 1'b0;
        got     = '0;
        @(posedge CLK);
        opValid    <= 1'b1;
        funcSel    <= vfuSelT'(sel[2:0]);
        aluOp      <= valuOpT'(op[4:0]);
        vsew       <= vsewT'(sew[1:0]);
        opUnsigned <= uns[0];
        maskBit    <= mask[0];
        vopA       <= a;
        vopB       <= b;
        vopC       <= a ^ b;
        @(posedge CLK);
        while (!opReady && waitCnt < 100) begin
            @(posedge CLK);
            waitCnt++;
        end
        opValid <= 1'b0;
        if (!opReady) begin
            $display("timeout: lane never became ready for %s", testName);
            timeouts++;
            timedOut = 1'b1;
        end else begin
            accepted++; // accepted at this edge
            while (!gotRes && cycles < 100) begin
                @(posedge CLK);
                cycles++;
                if (resValid) begin
                    gotRes = 1'b1;
                    got    = vres;
                end else begin
                    checks++;
                    assert (!opReady) else begin
                        $display("lane was ready again before the result of %s", testName);
                        otherErrors++;
                    end
                end
            end
            if (!gotRes) begin
                $display("timeout: no result valid for %s", testName);
                timeouts++;
                timedOut = 1'b1;
            end else begin
                checks++;
                assert (got === expVal) else begin
                    $display("MISMATCH %s expected %h actual %h", testName, expVal, got);
                    mismatches++;
                end
                if (sel < 3) begin // alu and pass ops have fixed latency
                    checks++;
                    assert (cycles - 1 == 2) else begin
                        $display("result of %s came %0d cycles after accept instead of 2",
                                 testName, cycles - 1);
                        otherErrors++;
                    end
                end
                @(posedge CLK);
                checks++;
                assert (!resValid) else begin
                    $display("result valid of %s stayed high a second cycle", testName);
                    otherErrors++;
                end
            end
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    sel;
        int    op;
        int    sew;
        int    uns;
        int    mask;
        wordT  a;
        wordT  b;
        wordT  expVal;
        string line;
        string testName;
        CLK         = 1'b0;
        rstN        = 1'b0;
        opValid     = 1'b0;
        funcSel     = vfuPassVs1;
        aluOp       = valuAdd;
        vsew        = sew32;
        opUnsigned  = 1'b0;
        maskBit     = 1'b0;
        vopA        = '0;
        vopB        = '0;
        vopC        = '0;
        mismatches  = 0;
        otherErrors = 0;
        timeouts    = 0;
        checks      = 0;
        accepted    = 0;
        timedOut    = 1'b0;
        repeat (2) @(posedge CLK);
        rstN <= 1'b1;
        @(posedge CLK);
        checks++;
        assert (opReady && !resValid) else begin
            $display("lane not idle after reset: ready %b, result valid %b", opReady, resValid);
            otherErrors++;
        end
        fd = $fopen("tests/vecLaneInput.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file tests/vecLaneInput.txt");
            otherErrors++;
        end else begin
            while (!timedOut && $fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin // skip comments, blanks
                    n = $sscanf(line, "%d %d %d %d %d %h %h %h %s",
                                sel, op, sew, uns, mask, a, b, expVal, testName);
                    if (n == 9) begin
                        applyVector(sel, op, sew, uns, mask, a, b, expVal, testName);
                    end else begin
                        $display("could not parse vector line: %s", line);
                        otherErrors++;
                    end
                end
            end
            $fclose(fd);
        end
        repeat (3) @(posedge CLK);
        checks++;
        assert (pulses == accepted) else begin
            $display("%0d result pulses seen for %0d accepted requests", pulses, accepted);
            otherErrors++;
        end
        $display("checks %0d, mismatches %0d, other errors %0d, timeouts %0d",
                 checks, mismatches, otherErrors, timeouts);
        if (mismatches + otherErrors + timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: tests/vecLaneInput.txt
# sel op sew uns mask vopA vopB expected name; sel 0 pass1, 1 pass2, 2 alu, 3 mul, 4 div
# op is the alu opcode number (mul 0 low, 23 high; div 0 quotient, 1 remainder); sew 0/1/2 = 8/16/32
2 0 2 0 0 ffffffff 00000002 00000001 addWrap
2 1 2 0 0 00000003 00000005 fffffffe subNeg
2 2 2 0 0 00000010 00000003 fffffff3 rsbNeg
2 4 2 0 1 ffffffff 00000000 00000000 adcCarryIn
2 5 2 0 1 00000000 00000000 ffffffff sbcBorrowIn
2 6 2 0 1 ffffffff 00000001 00000001 madcNoCarryIn
2 7 2 0 0 fffffffe 00000001 00000000 madcMask0
2 7 2 0 1 fffffffe 00000001 00000001 madcMask1
2 8 2 0 1 00000005 00000005 00000000 msbcNoBorrowIn
2 9 2 0 0 00000005 00000005 00000000 msbcMask0
2 9 2 0 1 00000005 00000005 00000001 msbcMask1
2 10 2 0 0 f0f0ff00 ff00f0f0 f000f000 andOp
2 11 2 0 0 f0f0ff00 ff00f0f0 0fff0fff nandOp
2 12 2 0 0 f0f0ff00 ff00f0f0 00f00f00 andnOp
2 13 2 0 0 f0f0ff00 ff00f0f0 fff0fff0 orOp
2 14 2 0 0 f0f0ff00 ff00f0f0 000f000f norOp
2 15 2 0 0 f0f0ff00 ff00f0f0 f0ffff0f ornOp
2 16 2 0 0 f0f0ff00 ff00f0f0 0ff00ff0 xorOp
2 17 2 0 0 f0f0ff00 ff00f0f0 f00ff00f xnorOp
2 18 0 0 0 80000000 0000000b 10000000 srlSew8
2 19 1 0 0 80000000 00000014 f8000000 sraSew16
2 20 2 0 0 00000001 00000025 00000020 sllSew32
2 28 2 0 0 11111111 22222222 11111111 mergeMask0
2 28 2 0 1 11111111 22222222 22222222 mergeMask1
2 29 2 0 0 11111111 33333333 33333333 intMove
0 0 2 0 0 aaaa5555 12345678 12345678 passVs1
1 0 2 0 0 aaaa5555 12345678 aaaa5555 passVs2
2 23 2 0 0 ffffffff 00000001 00000001 sltSigned
2 23 2 1 0 ffffffff 00000001 00000000 sltUnsigned
2 24 2 0 0 ffffffff 00000001 00000001 sleSigned
2 24 2 1 0 ffffffff 00000001 00000000 sleUnsigned
2 25 2 0 0 ffffffff 00000001 00000000 sgtSigned
2 25 2 1 0 ffffffff 00000001 00000001 sgtUnsigned
2 26 2 0 0 ffffffff 00000001 ffffffff minSigned
2 26 2 1 0 ffffffff 00000001 00000001 minUnsigned
2 27 2 0 0 ffffffff 00000001 00000001 maxSigned
2 27 2 1 0 ffffffff 00000001 ffffffff maxUnsigned
3 0 2 0 0 fffffffe 00000003 fffffffa mulLowSigned
3 23 2 0 0 fffffffe 00000003 ffffffff mulHighSigned
3 23 2 1 0 fffffffe 00000003 00000002 mulHighUnsigned
3 23 2 0 0 ffffffff ffffffff 00000000 mulHighNegNeg
3 23 2 1 0 ffffffff ffffffff fffffffe mulHighUnsMax
3 0 2 1 0 ffffffff ffffffff 00000001 mulLowUnsMax
4 0 2 0 0 ffffffec 00000006 fffffffd divQuotSigned
4 1 2 0 0 ffffffec 00000006 fffffffe divRemSigned
4 0 2 1 0 ffffffec 00000006 2aaaaaa7 divQuotUnsigned
4 1 2 1 0 ffffffec 00000006 00000002 divRemUnsigned
4 0 2 0 0 00000007 00000000 ffffffff divZeroQuot
4 1 2 0 0 00000007 00000000 00000007 divZeroRem
4 1 2 0 0 fffffff9 00000000 fffffff9 divZeroRemNeg
4 0 2 0 0 80000000 ffffffff 80000000 divOvfQuot
4 1 2 0 0 80000000 ffffffff 00000000 divOvfRem

// File: sim.f
source/vfuPkg.sv
source/vecAlu.sv
source/vecMultiplier.sv
source/vecDivider.sv
source/vecFuncUnit.sv
source/vecLane.sv
tests/vecLaneTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the lane testbench with Verilator, pass only if the log has the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module vecLaneTb \
    -f sim.f -o vecLaneSim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/vecLaneSim > sim.log 2>&1 ; cat sim.log
grep -qx "TB PASSED" sim.log && exit 0 || exit 1
